/* logic/gpu_mem_pkg.sv */
// GPU memory shared definitions
package gpu_mem_pkg;

    // Address and word widths of both memories
    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 8;
    localparam int INSTR_BITS = 16;

    // Consumers on each side of the memory system
    localparam int NUM_LSUS = 4;
    localparam int NUM_FETCHERS = 2;

    // Channels towards external memory, fewer than the consumers
    localparam int DATA_CHANNELS = 2;
    localparam int PROG_CHANNELS = 1;

    // Cycles from a bank seeing a new channel request to its ready pulse
    localparam int MEM_LATENCY = 3;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [INSTR_BITS-1:0] instr_t;

endpackage

/* logic/mem_controller.sv */
// Memory channel arbiter and relay
module mem_controller #(
    parameter int NUM_CONSUMERS = 4,
    parameter int NUM_CHANNELS = 2,
    parameter bit WRITE_ENABLE = 1'b1,
    parameter type word_t = gpu_mem_pkg::data_t
) (
    input  logic                     clk,
    input  logic                     reset,

    // Consumer side, one entry per fetcher or LSU
    input  logic [NUM_CONSUMERS-1:0] consumer_read_valid,
    input  gpu_mem_pkg::addr_t       consumer_read_address [NUM_CONSUMERS],
    output logic [NUM_CONSUMERS-1:0] consumer_read_ready,
    output word_t                    consumer_read_data [NUM_CONSUMERS],
    input  logic [NUM_CONSUMERS-1:0] consumer_write_valid,
    input  gpu_mem_pkg::addr_t       consumer_write_address [NUM_CONSUMERS],
    input  word_t                    consumer_write_data [NUM_CONSUMERS],
    output logic [NUM_CONSUMERS-1:0] consumer_write_ready,

    // Channel side, one entry per memory channel
    output logic [NUM_CHANNELS-1:0]  mem_read_valid,
    output gpu_mem_pkg::addr_t       mem_read_address [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0]  mem_read_ready,
    input  word_t                    mem_read_data [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0]  mem_write_valid,
    output gpu_mem_pkg::addr_t       mem_write_address [NUM_CHANNELS],
    output word_t                    mem_write_data [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0]  mem_write_ready
);
    typedef enum logic [2:0] {
        IDLE,
        READ_WAITING,
        WRITE_WAITING,
        READ_RELAYING,
        WRITE_RELAYING
    } chan_state_t;

    chan_state_t state [NUM_CHANNELS];
    logic [$clog2(NUM_CONSUMERS)-1:0] current_consumer [NUM_CHANNELS];

    // Consumers currently held by some channel
    logic [NUM_CONSUMERS-1:0] served;

    logic [NUM_CHANNELS-1:0] pick_valid;
    logic [NUM_CHANNELS-1:0] pick_write;
    logic [$clog2(NUM_CONSUMERS)-1:0] pick_consumer [NUM_CHANNELS];
    logic [NUM_CONSUMERS-1:0] taken;
    logic [NUM_CONSUMERS-1:0] write_request;

    // A read-only controller never sees a write request
    assign write_request = WRITE_ENABLE ? consumer_write_valid : '0;

    // Each idle channel takes the lowest pending consumer that no earlier
    // channel has already taken in this cycle
    always_comb begin
        taken = served;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            pick_valid[i] = 1'b0;
            pick_write[i] = 1'b0;
            pick_consumer[i] = '0;
            if (state[i] == IDLE) begin
                for (int j = 0; j < NUM_CONSUMERS; j++) begin
                    if (!pick_valid[i] && !taken[j] &&
                        (consumer_read_valid[j] || write_request[j])) begin
                        pick_valid[i] = 1'b1;
                        // Reads go ahead of writes from the same consumer
                        pick_write[i] = !consumer_read_valid[j];
                        pick_consumer[i] = j[$clog2(NUM_CONSUMERS)-1:0];
                        taken[j] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '{default: IDLE};
            current_consumer <= '{default: '0};
            served <= '0;
            consumer_read_ready <= '0;
            consumer_write_ready <= '0;
            mem_read_valid <= '0;
            mem_write_valid <= '0;
            mem_read_address <= '{default: '0};
            mem_write_address <= '{default: '0};
            mem_write_data <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                case (state[i])
                    IDLE: begin
                        if (pick_valid[i]) begin
                            current_consumer[i] <= pick_consumer[i];
                            served[pick_consumer[i]] <= 1'b1;
                            if (pick_write[i]) begin
                                mem_write_valid[i] <= 1'b1;
                                mem_write_address[i] <=
                                    consumer_write_address[pick_consumer[i]];
                                mem_write_data[i] <= consumer_write_data[pick_consumer[i]];
                                state[i] <= WRITE_WAITING;
                            end else begin
                                mem_read_valid[i] <= 1'b1;
                                mem_read_address[i] <= consumer_read_address[pick_consumer[i]];
                                state[i] <= READ_WAITING;
                            end
                        end
                    end
                    READ_WAITING: begin
                        if (mem_read_ready[i]) begin
                            mem_read_valid[i] <= 1'b0;
                            consumer_read_ready[current_consumer[i]] <= 1'b1;
                            state[i] <= READ_RELAYING;
                        end
                    end
                    WRITE_WAITING: begin
                        if (mem_write_ready[i]) begin
                            mem_write_valid[i] <= 1'b0;
                            consumer_write_ready[current_consumer[i]] <= 1'b1;
                            state[i] <= WRITE_RELAYING;
                        end
                    end
                    // Hold the response until the consumer lets go of valid
                    READ_RELAYING: begin
                        if (!consumer_read_valid[current_consumer[i]]) begin
                            consumer_read_ready[current_consumer[i]] <= 1'b0;
                            served[current_consumer[i]] <= 1'b0;
                            state[i] <= IDLE;
                        end
                    end
                    WRITE_RELAYING: begin
                        if (!consumer_write_valid[current_consumer[i]]) begin
                            consumer_write_ready[current_consumer[i]] <= 1'b0;
                            served[current_consumer[i]] <= 1'b0;
                            state[i] <= IDLE;
                        end
                    end
                    default: state[i] <= IDLE;
                endcase
            end
        end
    end

    // Read data is captured on the same edge that raises consumer ready
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (state[i] == READ_WAITING && mem_read_ready[i]) begin
                consumer_read_data[current_consumer[i]] <= mem_read_data[i];
            end
        end
    end

endmodule

/* logic/mem_bank.sv */
// Fixed-latency multi-channel memory
module mem_bank #(
    parameter int NUM_CHANNELS = 2,
    parameter bit WRITE_ENABLE = 1'b1,
    parameter bit LOAD_ENABLE = 1'b0,
    parameter type word_t = gpu_mem_pkg::data_t
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [NUM_CHANNELS-1:0] mem_read_valid,
    input  gpu_mem_pkg::addr_t      mem_read_address [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0] mem_read_ready,
    output word_t                   mem_read_data [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0] mem_write_valid,
    input  gpu_mem_pkg::addr_t      mem_write_address [NUM_CHANNELS],
    input  word_t                   mem_write_data [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0] mem_write_ready,

    // Single-cycle write strobe for preloading the array
    input  logic                    load_valid,
    input  gpu_mem_pkg::addr_t      load_address,
    input  word_t                   load_data
);
    import gpu_mem_pkg::*;

    word_t mem [2**ADDR_BITS];

    logic [NUM_CHANNELS-1:0] busy;
    logic [NUM_CHANNELS-1:0] done;
    logic [NUM_CHANNELS-1:0] op_write;
    logic [$clog2(MEM_LATENCY+1)-1:0] count [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] write_request;
    logic [NUM_CHANNELS-1:0] expire;

    assign write_request = WRITE_ENABLE ? mem_write_valid : '0;

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            expire[i] = busy[i] && (count[i] == MEM_LATENCY - 1);
        end
    end

    // Later channels overwrite earlier ones on the same address,
    // and the load port is applied last
    always_ff @(posedge clk) begin
        if (reset) begin
            mem <= '{default: '0};
            busy <= '0;
            done <= '0;
            op_write <= '0;
            count <= '{default: '0};
            mem_read_ready <= '0;
            mem_write_ready <= '0;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                mem_read_ready[i] <= 1'b0;
                mem_write_ready[i] <= 1'b0;
                if (expire[i]) begin
                    busy[i] <= 1'b0;
                    done[i] <= 1'b1;
                    if (op_write[i]) begin
                        mem[mem_write_address[i]] <= mem_write_data[i];
                        mem_write_ready[i] <= 1'b1;
                    end else begin
                        mem_read_ready[i] <= 1'b1;
                    end
                end else if (busy[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (done[i]) begin
                    // Wait for the controller to drop valid
                    if (!mem_read_valid[i] && !write_request[i]) begin
                        done[i] <= 1'b0;
                    end
                end else if (mem_read_valid[i] || write_request[i]) begin
                    busy[i] <= 1'b1;
                    op_write[i] <= !mem_read_valid[i];
                    count[i] <= '0;
                end
            end
            if (LOAD_ENABLE && load_valid) begin
                mem[load_address] <= load_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (expire[i] && !op_write[i]) begin
                mem_read_data[i] <= mem[mem_read_address[i]];
            end
        end
    end

endmodule

/* logic/gpu_mem_system.sv */
// SIMT GPU memory system
module gpu_mem_system (
    input  logic                                     clk,
    input  logic                                     reset,

    // Instruction fetchers
    input  logic [gpu_mem_pkg::NUM_FETCHERS-1:0]     fetcher_read_valid,
    input  gpu_mem_pkg::addr_t    fetcher_read_address [gpu_mem_pkg::NUM_FETCHERS],
    output logic [gpu_mem_pkg::NUM_FETCHERS-1:0]     fetcher_read_ready,
    output gpu_mem_pkg::instr_t   fetcher_read_data [gpu_mem_pkg::NUM_FETCHERS],

    // Load/store units
    input  logic [gpu_mem_pkg::NUM_LSUS-1:0]         lsu_read_valid,
    input  gpu_mem_pkg::addr_t    lsu_read_address [gpu_mem_pkg::NUM_LSUS],
    output logic [gpu_mem_pkg::NUM_LSUS-1:0]         lsu_read_ready,
    output gpu_mem_pkg::data_t    lsu_read_data [gpu_mem_pkg::NUM_LSUS],
    input  logic [gpu_mem_pkg::NUM_LSUS-1:0]         lsu_write_valid,
    input  gpu_mem_pkg::addr_t    lsu_write_address [gpu_mem_pkg::NUM_LSUS],
    input  gpu_mem_pkg::data_t    lsu_write_data [gpu_mem_pkg::NUM_LSUS],
    output logic [gpu_mem_pkg::NUM_LSUS-1:0]         lsu_write_ready,

    // Program image load port
    input  logic                                     prog_load_valid,
    input  gpu_mem_pkg::addr_t                       prog_load_address,
    input  gpu_mem_pkg::instr_t                      prog_load_data
);
    import gpu_mem_pkg::*;

    // Fetchers never write, so their write side is tied off
    addr_t  fetcher_write_address [NUM_FETCHERS];
    instr_t fetcher_write_data [NUM_FETCHERS];

    assign fetcher_write_address = '{default: '0};
    assign fetcher_write_data = '{default: '0};

    // Program channels
    logic [PROG_CHANNELS-1:0] prog_read_valid;
    addr_t                    prog_read_address [PROG_CHANNELS];
    logic [PROG_CHANNELS-1:0] prog_read_ready;
    instr_t                   prog_read_data [PROG_CHANNELS];
    logic [PROG_CHANNELS-1:0] prog_write_valid;
    addr_t                    prog_write_address [PROG_CHANNELS];
    instr_t                   prog_write_data [PROG_CHANNELS];
    logic [PROG_CHANNELS-1:0] prog_write_ready;

    // Data channels
    logic [DATA_CHANNELS-1:0] data_read_valid;
    addr_t                    data_read_address [DATA_CHANNELS];
    logic [DATA_CHANNELS-1:0] data_read_ready;
    data_t                    data_read_data [DATA_CHANNELS];
    logic [DATA_CHANNELS-1:0] data_write_valid;
    addr_t                    data_write_address [DATA_CHANNELS];
    data_t                    data_write_data [DATA_CHANNELS];
    logic [DATA_CHANNELS-1:0] data_write_ready;

    mem_controller #(
        .NUM_CONSUMERS (NUM_FETCHERS),
        .NUM_CHANNELS  (PROG_CHANNELS),
        .WRITE_ENABLE  (1'b0),
        .word_t        (instr_t)
    ) prog_controller (
        .clk                    (clk),
        .reset                  (reset),
        .consumer_read_valid    (fetcher_read_valid),
        .consumer_read_address  (fetcher_read_address),
        .consumer_read_ready    (fetcher_read_ready),
        .consumer_read_data     (fetcher_read_data),
        .consumer_write_valid   ('0),
        .consumer_write_address (fetcher_write_address),
        .consumer_write_data    (fetcher_write_data),
        .consumer_write_ready   (),
        .mem_read_valid         (prog_read_valid),
        .mem_read_address       (prog_read_address),
        .mem_read_ready         (prog_read_ready),
        .mem_read_data          (prog_read_data),
        .mem_write_valid        (prog_write_valid),
        .mem_write_address      (prog_write_address),
        .mem_write_data         (prog_write_data),
        .mem_write_ready        (prog_write_ready)
    );

    mem_bank #(
        .NUM_CHANNELS (PROG_CHANNELS),
        .WRITE_ENABLE (1'b0),
        .LOAD_ENABLE  (1'b1),
        .word_t       (instr_t)
    ) prog_bank (
        .clk               (clk),
        .reset             (reset),
        .mem_read_valid    (prog_read_valid),
        .mem_read_address  (prog_read_address),
        .mem_read_ready    (prog_read_ready),
        .mem_read_data     (prog_read_data),
        .mem_write_valid   (prog_write_valid),
        .mem_write_address (prog_write_address),
        .mem_write_data    (prog_write_data),
        .mem_write_ready   (prog_write_ready),
        .load_valid        (prog_load_valid),
        .load_address      (prog_load_address),
        .load_data         (prog_load_data)
    );

    mem_controller #(
        .NUM_CONSUMERS (NUM_LSUS),
        .NUM_CHANNELS  (DATA_CHANNELS),
        .WRITE_ENABLE  (1'b1),
        .word_t        (data_t)
    ) data_controller (
        .clk                    (clk),
        .reset                  (reset),
        .consumer_read_valid    (lsu_read_valid),
        .consumer_read_address  (lsu_read_address),
        .consumer_read_ready    (lsu_read_ready),
        .consumer_read_data     (lsu_read_data),
        .consumer_write_valid   (lsu_write_valid),
        .consumer_write_address (lsu_write_address),
        .consumer_write_data    (lsu_write_data),
        .consumer_write_ready   (lsu_write_ready),
        .mem_read_valid         (data_read_valid),
        .mem_read_address       (data_read_address),
        .mem_read_ready         (data_read_ready),
        .mem_read_data          (data_read_data),
        .mem_write_valid        (data_write_valid),
        .mem_write_address      (data_write_address),
        .mem_write_data         (data_write_data),
        .mem_write_ready        (data_write_ready)
    );

    mem_bank #(
        .NUM_CHANNELS (DATA_CHANNELS),
        .WRITE_ENABLE (1'b1),
        .LOAD_ENABLE  (1'b0),
        .word_t       (data_t)
    ) data_bank (
        .clk               (clk),
        .reset             (reset),
        .mem_read_valid    (data_read_valid),
        .mem_read_address  (data_read_address),
        .mem_read_ready    (data_read_ready),
        .mem_read_data     (data_read_data),
        .mem_write_valid   (data_write_valid),
        .mem_write_address (data_write_address),
        .mem_write_data    (data_write_data),
        .mem_write_ready   (data_write_ready),
        .load_valid        (1'b0),
        .load_address      ('0),
        .load_data         ('0)
    );

endmodule

/* tests/mem_controller_chk.sv */
// Memory controller handshake checks
module mem_controller_chk #(
    parameter int NUM_CONSUMERS = 4,
    parameter int NUM_CHANNELS = 2,
    parameter bit WRITE_ENABLE = 1'b1
) (
    input logic                     clk,
    input logic                     reset,
    input logic [NUM_CONSUMERS-1:0] consumer_read_valid,
    input logic [NUM_CONSUMERS-1:0] consumer_read_ready,
    input logic [NUM_CONSUMERS-1:0] consumer_write_valid,
    input logic [NUM_CONSUMERS-1:0] consumer_write_ready,
    input logic [NUM_CHANNELS-1:0]  mem_read_valid,
    input logic [NUM_CHANNELS-1:0]  mem_read_ready,
    input logic [NUM_CHANNELS-1:0]  mem_write_valid,
    input logic [NUM_CHANNELS-1:0]  mem_write_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        read_hold: assert property (@(posedge clk) disable iff (reset)
            mem_read_valid[i] && !mem_read_ready[i] |=> mem_read_valid[i])
            else $error("channel %0d read valid dropped before ready", i);
        write_hold: assert property (@(posedge clk) disable iff (reset)
            mem_write_valid[i] && !mem_write_ready[i] |=> mem_write_valid[i])
            else $error("channel %0d write valid dropped before ready", i);
        one_op: assert property (@(posedge clk) disable iff (reset)
            !(mem_read_valid[i] && mem_write_valid[i]))
            else $error("channel %0d has read and write valid together", i);
    end

    // Ready answers a request, so valid was high on the edge that raised it
    for (genvar j = 0; j < NUM_CONSUMERS; j++) begin : g_cons
        read_answer: assert property (@(posedge clk) disable iff (reset)
            $rose(consumer_read_ready[j]) |-> $past(consumer_read_valid[j]))
            else $error("consumer %0d read ready rose without valid", j);
        write_answer: assert property (@(posedge clk) disable iff (reset)
            $rose(consumer_write_ready[j]) |-> $past(consumer_write_valid[j]))
            else $error("consumer %0d write ready rose without valid", j);
    end

    no_write: assert property (@(posedge clk) disable iff (reset)
        WRITE_ENABLE || (mem_write_valid == '0))
        else $error("write valid on a read-only controller");

endmodule

/* tests/gpu_mem_system_tb.sv */
// GPU memory system testbench
module gpu_mem_system_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import gpu_mem_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk;
    logic reset;
    logic [NUM_FETCHERS-1:0] fetcher_read_valid;
    addr_t fetcher_read_address [NUM_FETCHERS];
    logic [NUM_FETCHERS-1:0] fetcher_read_ready;
    instr_t fetcher_read_data [NUM_FETCHERS];
    logic [NUM_LSUS-1:0] lsu_read_valid;
    addr_t lsu_read_address [NUM_LSUS];
    logic [NUM_LSUS-1:0] lsu_read_ready;
    data_t lsu_read_data [NUM_LSUS];
    logic [NUM_LSUS-1:0] lsu_write_valid;
    addr_t lsu_write_address [NUM_LSUS];
    data_t lsu_write_data [NUM_LSUS];
    logic [NUM_LSUS-1:0] lsu_write_ready;
    logic prog_load_valid;
    addr_t prog_load_address;
    instr_t prog_load_data;

    // Shadow copies of both memories
    data_t data_shadow [2**ADDR_BITS];
    instr_t prog_shadow [2**ADDR_BITS];

    int errors = 0;
    int timeouts = 0;
    int reads_checked = 0;
    int seed = 32'hd107;
    bit others_done;
    data_t wdata [NUM_LSUS][4];

    gpu_mem_system dut (.*);

    bind mem_controller mem_controller_chk #(
        .NUM_CONSUMERS (NUM_CONSUMERS),
        .NUM_CHANNELS  (NUM_CHANNELS),
        .WRITE_ENABLE  (WRITE_ENABLE)
    ) chk (
        .clk                  (clk),
        .reset                (reset),
        .consumer_read_valid  (consumer_read_valid),
        .consumer_read_ready  (consumer_read_ready),
        .consumer_write_valid (consumer_write_valid),
        .consumer_write_ready (consumer_write_ready),
        .mem_read_valid       (mem_read_valid),
        .mem_read_ready       (mem_read_ready),
        .mem_write_valid      (mem_write_valid),
        .mem_write_ready      (mem_write_ready)
    );

    function automatic data_t expected_data(input addr_t addr);
        return data_shadow[addr];
    endfunction

    function automatic instr_t expected_instr(input addr_t addr);
        return prog_shadow[addr];
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Read on one LSU, optionally holding valid for some cycles after ready
    task automatic lsu_read(input int idx, input addr_t addr, input int hold);
        int cycles;
        lsu_read_address[idx] = addr;
        lsu_read_valid[idx] = 1'b1;
        cycles = 0;
        while (!lsu_read_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!lsu_read_ready[idx]) begin
            $display("LSU %0d read of address %h never got ready", idx, addr);
            timeouts++;
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
            if (!lsu_read_ready[idx]) begin
                $display("LSU %0d ready dropped while valid was still held", idx);
                errors++;
            end
        end
        if (hold > 0 && !others_done) begin
            $display("Other LSUs were not served while LSU %0d held its channel", idx);
            errors++;
        end
        lsu_read_valid[idx] = 1'b0;
        cycles = 0;
        while (lsu_read_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (lsu_read_ready[idx]) begin
            $display("LSU %0d read ready stayed high after valid dropped", idx);
            timeouts++;
        end
    endtask

    task automatic lsu_write(input int idx, input addr_t addr, input data_t data);
        int cycles;
        lsu_write_address[idx] = addr;
        lsu_write_data[idx] = data;
        lsu_write_valid[idx] = 1'b1;
        cycles = 0;
        while (!lsu_write_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (lsu_write_ready[idx]) begin
            data_shadow[addr] = data;
        end else begin
            $display("LSU %0d write to address %h never got ready", idx, addr);
            timeouts++;
        end
        lsu_write_valid[idx] = 1'b0;
        cycles = 0;
        while (lsu_write_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (lsu_write_ready[idx]) begin
            $display("LSU %0d write ready stayed high after valid dropped", idx);
            timeouts++;
        end
    endtask

    task automatic fetcher_read(input int idx, input addr_t addr);
        int cycles;
        fetcher_read_address[idx] = addr;
        fetcher_read_valid[idx] = 1'b1;
        cycles = 0;
        while (!fetcher_read_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!fetcher_read_ready[idx]) begin
            $display("Fetcher %0d read of address %h never got ready", idx, addr);
            timeouts++;
        end
        fetcher_read_valid[idx] = 1'b0;
        cycles = 0;
        while (fetcher_read_ready[idx] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (fetcher_read_ready[idx]) begin
            $display("Fetcher %0d ready stayed high after valid dropped", idx);
            timeouts++;
        end
    endtask

    task automatic load_word(input addr_t addr, input instr_t data);
        prog_load_valid = 1'b1;
        prog_load_address = addr;
        prog_load_data = data;
        @(posedge clk);
        #1;
        prog_shadow[addr] = data;
        prog_load_valid = 1'b0;
    endtask

    // Checks every new read response, and that a held response stays put
    initial begin
        logic [NUM_LSUS-1:0] lsu_prev;
        logic [NUM_FETCHERS-1:0] fetcher_prev;
        data_t lsu_held [NUM_LSUS];
        lsu_prev = '0;
        fetcher_prev = '0;
        forever begin
            @(posedge clk);
            #2;
            for (int i = 0; i < NUM_LSUS; i++) begin
                if (lsu_read_ready[i] === 1'b1 && !lsu_prev[i]) begin
                    reads_checked++;
                    lsu_held[i] = lsu_read_data[i];
                    if (lsu_read_data[i] !== expected_data(lsu_read_address[i])) begin
                        $display("ERROR lsu_read_data[%0d] addr %h: got %h expected %h", i,
                                 lsu_read_address[i], lsu_read_data[i],
                                 expected_data(lsu_read_address[i]));
                        errors++;
                    end
                end else if (lsu_read_ready[i] === 1'b1 && lsu_read_data[i] !== lsu_held[i]) begin
                    $display("ERROR lsu_read_data[%0d] held: got %h expected %h", i,
                             lsu_read_data[i], lsu_held[i]);
                    errors++;
                end
                lsu_prev[i] = (lsu_read_ready[i] === 1'b1);
            end
            for (int i = 0; i < NUM_FETCHERS; i++) begin
                if (fetcher_read_ready[i] === 1'b1 && !fetcher_prev[i]) begin
                    reads_checked++;
                    if (fetcher_read_data[i] !== expected_instr(fetcher_read_address[i])) begin
                        $display("ERROR fetcher_read_data[%0d] addr %h: got %h expected %h", i,
                                 fetcher_read_address[i], fetcher_read_data[i],
                                 expected_instr(fetcher_read_address[i]));
                        errors++;
                    end
                end
                fetcher_prev[i] = (fetcher_read_ready[i] === 1'b1);
            end
        end
    end

    initial begin
        data_shadow = '{default: '0};
        prog_shadow = '{default: '0};
        reset = 1'b1;
        fetcher_read_valid = '0;
        fetcher_read_address = '{default: '0};
        lsu_read_valid = '0;
        lsu_read_address = '{default: '0};
        lsu_write_valid = '0;
        lsu_write_address = '{default: '0};
        lsu_write_data = '{default: '0};
        prog_load_valid = 1'b0;
        prog_load_address = '0;
        prog_load_data = '0;
        for (int i = 0; i < NUM_LSUS; i++) begin
            for (int k = 0; k < 4; k++) begin
                wdata[i][k] = data_t'($random(seed));
            end
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        if (fetcher_read_ready !== '0 || lsu_read_ready !== '0 || lsu_write_ready !== '0) begin
            $display("A ready output was not low after reset");
            errors++;
        end
        lsu_read(0, 8'h00, 0);
        lsu_read(1, 8'hff, 0);
        lsu_read(2, 8'h5a, 0);

        // Every LSU writes its own addresses, all competing for two channels
        for (int i = 0; i < NUM_LSUS; i++) begin
            fork
                automatic int n = i;
                for (int k = 0; k < 4; k++) begin
                    lsu_write(n, addr_t'(8'h20 + n * 16 + k), wdata[n][k]);
                end
            join_none
        end
        wait fork;
        for (int k = 0; k < 4; k++) begin
            fork
                lsu_read(0, addr_t'(8'h20 + k), 0);
                lsu_read(1, addr_t'(8'h30 + k), 0);
                lsu_read(2, addr_t'(8'h40 + k), 0);
                lsu_read(3, addr_t'(8'h50 + k), 0);
            join
        end

        for (int k = 0; k < 6; k++) begin
            load_word(addr_t'(8'h80 + k * 3), instr_t'($random(seed)));
        end
        for (int k = 0; k < 6; k++) begin
            fork
                fetcher_read(0, addr_t'(8'h80 + k * 3));
                fetcher_read(1, addr_t'(8'h80 + (5 - k) * 3));
            join
        end

        // LSU 0 keeps its channel while the rest share the other one
        others_done = 1'b0;
        fork
            lsu_read(0, 8'h21, 60);
            begin
                fork
                    lsu_read(1, 8'h31, 0);
                    lsu_read(2, 8'h42, 0);
                    lsu_read(3, 8'h53, 0);
                join
                others_done = 1'b1;
            end
        join

        repeat (4) @(posedge clk);
        if (reads_checked == 0) begin
            $display("No read response was ever checked");
            errors++;
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d reads checked",
                 errors, timeouts, reads_checked);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* gpu_mem_system.f */
logic/gpu_mem_pkg.sv
logic/mem_controller.sv
logic/mem_bank.sv
logic/gpu_mem_system.sv
tests/mem_controller_chk.sv
tests/gpu_mem_system_tb.sv

/* Bender.yml */
package:
  name: gpu_mem_system

sources:
  - logic/gpu_mem_pkg.sv
  - logic/mem_controller.sv
  - logic/mem_bank.sv
  - logic/gpu_mem_system.sv
  - target: test
    files:
      - tests/mem_controller_chk.sv
      - tests/gpu_mem_system_tb.sv
